//--- rtl/decode_pkg.sv
/* Decode stage types and codes */

`default_nettype none

package decode_pkg;

    localparam int NUM_REGS = 8;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  ext_mode_t;
    typedef logic [1:0]  dst_sel_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [2:0]  wb_sel_t;

    // Immediate extension modes.
    localparam ext_mode_t EXT_S5  = 3'd0;
    localparam ext_mode_t EXT_Z5  = 3'd1;
    localparam ext_mode_t EXT_S8  = 3'd2;
    localparam ext_mode_t EXT_Z8  = 3'd3;
    localparam ext_mode_t EXT_S11 = 3'd4;

    // Destination register field.
    localparam dst_sel_t DST_RD_R = 2'd0; // Bits 4:2.
    localparam dst_sel_t DST_RD_I = 2'd1; // Bits 7:5.
    localparam dst_sel_t DST_RS   = 2'd2; // Bits 10:8.
    localparam dst_sel_t DST_R7   = 2'd3; // Link register.

    localparam alu_op_t ALU_ROL = 3'd0;
    localparam alu_op_t ALU_SLL = 3'd1;
    localparam alu_op_t ALU_ROR = 3'd2;
    localparam alu_op_t ALU_SRL = 3'd3;
    localparam alu_op_t ALU_ADD = 3'd4;
    localparam alu_op_t ALU_OR  = 3'd5;
    localparam alu_op_t ALU_XOR = 3'd6;
    localparam alu_op_t ALU_AND = 3'd7;

    localparam wb_sel_t WB_ALU  = 3'd0;
    localparam wb_sel_t WB_MEM  = 3'd1;
    localparam wb_sel_t WB_PC2  = 3'd2;
    localparam wb_sel_t WB_SET  = 3'd3;
    localparam wb_sel_t WB_IMM  = 3'd4;
    localparam wb_sel_t WB_BTR  = 3'd5;
    localparam wb_sel_t WB_SLBI = 3'd6;

    localparam opcode_t OP_HALT    = 5'b00000;
    localparam opcode_t OP_NOP     = 5'b00001;
    localparam opcode_t OP_NOP_RTI = 5'b00011;
    localparam opcode_t OP_J       = 5'b00100;
    localparam opcode_t OP_JR      = 5'b00101;
    localparam opcode_t OP_JAL     = 5'b00110;
    localparam opcode_t OP_JALR    = 5'b00111;
    localparam opcode_t OP_ADDI    = 5'b01000;
    localparam opcode_t OP_SUBI    = 5'b01001;
    localparam opcode_t OP_XORI    = 5'b01010;
    localparam opcode_t OP_ANDNI   = 5'b01011;
    localparam opcode_t OP_BEQZ    = 5'b01100;
    localparam opcode_t OP_BNEZ    = 5'b01101;
    localparam opcode_t OP_BLTZ    = 5'b01110;
    localparam opcode_t OP_BGEZ    = 5'b01111;
    localparam opcode_t OP_ST      = 5'b10000;
    localparam opcode_t OP_LD      = 5'b10001;
    localparam opcode_t OP_SLBI    = 5'b10010;
    localparam opcode_t OP_STU     = 5'b10011;
    localparam opcode_t OP_ROLI    = 5'b10100;
    localparam opcode_t OP_SLLI    = 5'b10101;
    localparam opcode_t OP_RORI    = 5'b10110;
    localparam opcode_t OP_SRLI    = 5'b10111;
    localparam opcode_t OP_LBI     = 5'b11000;
    localparam opcode_t OP_BTR     = 5'b11001;
    localparam opcode_t OP_SHF_RR  = 5'b11010;
    localparam opcode_t OP_ALU_RR  = 5'b11011;
    localparam opcode_t OP_SEQ     = 5'b11100;
    localparam opcode_t OP_SLT     = 5'b11101;
    localparam opcode_t OP_SLE     = 5'b11110;
    localparam opcode_t OP_SCO     = 5'b11111;

    // Control bundle sent on to execute, memory and writeback.
    typedef struct packed {
        logic [1:0]  br_cnd_sel;
        logic [1:0]  set_sel;
        logic        wr_en;
        logic        has_rt;
        logic        mem_wr_en;
        logic        mem_en;
        wb_sel_t     wr_sel;
        logic        jmp_reg_instr;
        logic        jmp_instr;
        logic        br_instr;
        alu_op_t     alu_op;
        logic        alu_inv_a;
        logic        alu_inv_b;
        logic        alu_cin;
        logic        alu_sign;
        logic        halt;
    } decode_ctrl_t;

    // Selectors used inside the stage only.
    typedef struct packed {
        ext_mode_t ext_mode;
        dst_sel_t  dst_sel;
        logic      oprnd_sel; // Second operand is the immediate.
    } decode_sel_t;

endpackage

`default_nettype wire

//--- rtl/reg_file_bypass.sv
/* Register file with write bypass */

`timescale 1ns/1ps
`default_nettype none

module reg_file_bypass
    import decode_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire reg_idx_t rd_reg_1,
    input  wire reg_idx_t rd_reg_2,
    input  wire logic     wr_en,
    input  wire reg_idx_t wr_reg,
    input  wire word_t    wr_data,
    output word_t         rd_data_1,
    output word_t         rd_data_2
);

    word_t regs [NUM_REGS];

    logic hit_1;
    logic hit_2;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // A read of the register being written sees the new value.
    assign hit_1 = wr_en && (wr_reg == rd_reg_1);
    assign hit_2 = wr_en && (wr_reg == rd_reg_2);

    assign rd_data_1 = hit_1 ? wr_data : regs[rd_reg_1];
    assign rd_data_2 = hit_2 ? wr_data : regs[rd_reg_2];

    // Writeback must drive a known write strobe and index once out of reset.
    a_wr_known : assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown({wr_en, wr_reg})
    ) else $error("Write port unknown: wr_en=%b wr_reg=%b", wr_en, wr_reg);

endmodule

`default_nettype wire

//--- rtl/sign_ext.sv
/* Immediate extender */

`timescale 1ns/1ps
`default_nettype none

module sign_ext
    import decode_pkg::*;
(
    input  wire word_t     instr,
    input  wire ext_mode_t ext_mode,
    output word_t          imm
);

    always_comb begin
        case (ext_mode)
            EXT_S5:  imm = {{11{instr[4]}}, instr[4:0]};
            EXT_Z5:  imm = {11'b0, instr[4:0]};
            EXT_S8:  imm = {{8{instr[7]}}, instr[7:0]};
            EXT_Z8:  imm = {8'b0, instr[7:0]};
            EXT_S11: imm = {{5{instr[10]}}, instr[10:0]};
            default: imm = '0;
        endcase
    end

    // Control only produces the five defined modes.
    always_comb begin
        assert (ext_mode <= EXT_S11)
            else $error("Undefined extension mode %0d", ext_mode);
    end

endmodule

`default_nettype wire

//--- rtl/control.sv
/* Instruction control decoder */

`timescale 1ns/1ps
`default_nettype none

module control
    import decode_pkg::*;
(
    input  wire word_t   instr,
    output decode_ctrl_t ctrl,
    output decode_sel_t  sel,
    output logic         illegal
);

    opcode_t    opcode;
    logic [1:0] func;

    assign opcode = instr[15:11];
    assign func   = instr[1:0];

    always_comb begin
        ctrl    = '0;
        sel     = '0;
        illegal = 1'b0;

        case (opcode)
            OP_HALT:    ctrl.halt = 1'b1;
            OP_NOP, OP_NOP_RTI: begin
            end

            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                ctrl.wr_en    = 1'b1;
                ctrl.wr_sel   = WB_ALU;
                sel.dst_sel   = DST_RD_I;
                sel.oprnd_sel = 1'b1;
                sel.ext_mode  = EXT_Z5;
                case (opcode)
                    OP_ADDI: begin
                        ctrl.alu_op   = ALU_ADD;
                        ctrl.alu_sign = 1'b1;
                        sel.ext_mode  = EXT_S5;
                    end
                    OP_SUBI: begin // Immediate minus Rs.
                        ctrl.alu_op    = ALU_ADD;
                        ctrl.alu_inv_a = 1'b1;
                        ctrl.alu_cin   = 1'b1;
                        ctrl.alu_sign  = 1'b1;
                        sel.ext_mode   = EXT_S5;
                    end
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_ANDNI: begin
                        ctrl.alu_op    = ALU_AND;
                        ctrl.alu_inv_b = 1'b1;
                    end
                    OP_ROLI:  ctrl.alu_op = ALU_ROL;
                    OP_SLLI:  ctrl.alu_op = ALU_SLL;
                    OP_RORI:  ctrl.alu_op = ALU_ROR;
                    default:  ctrl.alu_op = ALU_SRL;
                endcase
            end

            OP_ST, OP_LD, OP_STU: begin
                ctrl.mem_en   = 1'b1;
                ctrl.alu_op   = ALU_ADD; // Address is Rs plus offset.
                sel.oprnd_sel = 1'b1;
                sel.ext_mode  = EXT_S5;
                if (opcode == OP_LD) begin
                    ctrl.wr_en  = 1'b1;
                    ctrl.wr_sel = WB_MEM;
                    sel.dst_sel = DST_RS;
                end else begin
                    ctrl.mem_wr_en = 1'b1;
                    ctrl.has_rt    = 1'b1;
                end
                if (opcode == OP_STU) begin // Rs takes the address.
                    ctrl.wr_en  = 1'b1;
                    ctrl.wr_sel = WB_ALU;
                    sel.dst_sel = DST_RS;
                end
            end

            OP_BTR: begin
                ctrl.wr_en  = 1'b1;
                ctrl.wr_sel = WB_BTR;
                sel.dst_sel = DST_RD_R;
            end

            OP_ALU_RR, OP_SHF_RR: begin
                ctrl.wr_en  = 1'b1;
                ctrl.has_rt = 1'b1;
                ctrl.wr_sel = WB_ALU;
                sel.dst_sel = DST_RD_R;
                if (opcode == OP_SHF_RR) begin
                    case (func)
                        2'b00:   ctrl.alu_op = ALU_ROL;
                        2'b01:   ctrl.alu_op = ALU_SLL;
                        2'b10:   ctrl.alu_op = ALU_ROR;
                        default: ctrl.alu_op = ALU_SRL;
                    endcase
                end else begin
                    case (func)
                        2'b00: begin
                            ctrl.alu_op   = ALU_ADD;
                            ctrl.alu_sign = 1'b1;
                        end
                        2'b01: begin // Rt minus Rs.
                            ctrl.alu_op    = ALU_ADD;
                            ctrl.alu_inv_a = 1'b1;
                            ctrl.alu_cin   = 1'b1;
                            ctrl.alu_sign  = 1'b1;
                        end
                        2'b10:   ctrl.alu_op = ALU_XOR;
                        default: begin
                            ctrl.alu_op    = ALU_AND;
                            ctrl.alu_inv_b = 1'b1;
                        end
                    endcase
                end
            end

            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                ctrl.wr_en   = 1'b1;
                ctrl.has_rt  = 1'b1;
                ctrl.wr_sel  = WB_SET;
                ctrl.set_sel = opcode[1:0];
                ctrl.alu_op  = ALU_ADD;
                sel.dst_sel  = DST_RD_R;
                if (opcode != OP_SCO) begin // Compare through Rs minus Rt.
                    ctrl.alu_inv_b = 1'b1;
                    ctrl.alu_cin   = 1'b1;
                    ctrl.alu_sign  = 1'b1;
                end
            end

            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctrl.br_instr   = 1'b1;
                ctrl.br_cnd_sel = opcode[1:0];
                sel.ext_mode    = EXT_S8;
            end

            OP_LBI: begin
                ctrl.wr_en    = 1'b1;
                ctrl.wr_sel   = WB_IMM;
                sel.dst_sel   = DST_RS;
                sel.oprnd_sel = 1'b1;
                sel.ext_mode  = EXT_S8;
            end

            OP_SLBI: begin // Execute shifts Rs by 8 ahead of the OR.
                ctrl.wr_en    = 1'b1;
                ctrl.wr_sel   = WB_SLBI;
                ctrl.alu_op   = ALU_OR;
                sel.dst_sel   = DST_RS;
                sel.oprnd_sel = 1'b1;
                sel.ext_mode  = EXT_Z8;
            end

            OP_J, OP_JAL, OP_JR, OP_JALR: begin
                ctrl.jmp_instr = 1'b1;
                sel.ext_mode   = EXT_S11;
                if (opcode == OP_JR || opcode == OP_JALR) begin
                    ctrl.jmp_reg_instr = 1'b1;
                    ctrl.alu_op        = ALU_ADD; // Target is Rs plus offset.
                    sel.oprnd_sel      = 1'b1;
                    sel.ext_mode       = EXT_S8;
                end
                if (opcode == OP_JAL || opcode == OP_JALR) begin
                    ctrl.wr_en  = 1'b1;
                    ctrl.wr_sel = WB_PC2;
                    sel.dst_sel = DST_R7;
                end
            end

            default: illegal = 1'b1;
        endcase
    end

    // A store always runs a memory access.
    always_comb begin
        assert (!ctrl.mem_wr_en || ctrl.mem_en)
            else $error("mem_wr_en without mem_en, opcode %b", opcode);
    end

endmodule

`default_nettype wire

//--- rtl/decode.sv
/* Decode stage top */

`timescale 1ns/1ps
`default_nettype none

module decode
    import decode_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire word_t    instr,
    input  wire reg_idx_t rd_reg_1,
    input  wire reg_idx_t rd_reg_2,
    input  wire logic     wr_en,
    input  wire reg_idx_t wr_reg,
    input  wire word_t    wr_data,
    output word_t         rd_data_1,
    output word_t         rd_data_2,
    output word_t         oprnd_2,
    output word_t         sext_imm,
    output reg_idx_t      out_wr_reg,
    output decode_ctrl_t  ctrl,
    output logic          err
);

    decode_sel_t sel;
    logic        illegal;

    reg_file_bypass u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_reg_1  (rd_reg_1),
        .rd_reg_2  (rd_reg_2),
        .wr_en     (wr_en),
        .wr_reg    (wr_reg),
        .wr_data   (wr_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    control u_control (
        .instr   (instr),
        .ctrl    (ctrl),
        .sel     (sel),
        .illegal (illegal)
    );

    sign_ext u_sign_ext (
        .instr    (instr),
        .ext_mode (sel.ext_mode),
        .imm      (sext_imm)
    );

    // Destination register for writeback.
    always_comb begin
        case (sel.dst_sel)
            DST_RD_R: out_wr_reg = instr[4:2];
            DST_RD_I: out_wr_reg = instr[7:5];
            DST_RS:   out_wr_reg = instr[10:8];
            default:  out_wr_reg = 3'd7;
        endcase
    end

    assign oprnd_2 = sel.oprnd_sel ? sext_imm : rd_data_2;

    assign err = illegal;

    // An illegal opcode must never leave a side effect enabled.
    a_illegal_quiet : assert property (
        @(posedge clk) disable iff (reset)
        err |-> !(ctrl.wr_en || ctrl.mem_en || ctrl.mem_wr_en
                  || ctrl.br_instr || ctrl.jmp_instr || ctrl.halt)
    ) else $error("Enable raised on illegal opcode %b", instr[15:11]);

    // A link write always targets register 7.
    a_link_r7 : assert property (
        @(posedge clk) disable iff (reset)
        (ctrl.wr_en && ctrl.wr_sel == WB_PC2) |-> (out_wr_reg == 3'd7)
    ) else $error("Link write to register %0d", out_wr_reg);

endmodule

`default_nettype wire

//--- bench/decode_tb.sv
/* Decode stage testbench */

`timescale 1ns/1ps
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int SAMPLE_MARGIN = 2;
    localparam int RESET_CYCLES  = 3;
    localparam int RESET_LIMIT   = 10;
    localparam int TRACE_LIMIT   = 200;
    localparam int MIN_VECTORS   = 40;

    logic         clk;
    logic         reset;
    word_t        instr;
    reg_idx_t     rd_reg_1;
    reg_idx_t     rd_reg_2;
    logic         wr_en;
    reg_idx_t     wr_reg;
    word_t        wr_data;
    word_t        rd_data_1;
    word_t        rd_data_2;
    word_t        oprnd_2;
    word_t        sext_imm;
    reg_idx_t     out_wr_reg;
    decode_ctrl_t ctrl;
    logic         err;

    // Expected outputs of the current trace line.
    word_t                           exp_rd_data_1;
    word_t                           exp_rd_data_2;
    word_t                           exp_oprnd_2;
    word_t                           exp_sext_imm;
    reg_idx_t                        exp_wr_reg;
    logic [$bits(decode_ctrl_t)-1:0] exp_ctrl_raw;
    logic                            exp_err;

    int   errors;
    int   checks;
    int   vectors;
    logic aborted;

    decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .rd_reg_1   (rd_reg_1),
        .rd_reg_2   (rd_reg_2),
        .wr_en      (wr_en),
        .wr_reg     (wr_reg),
        .wr_data    (wr_data),
        .rd_data_1  (rd_data_1),
        .rd_data_2  (rd_data_2),
        .oprnd_2    (oprnd_2),
        .sext_imm   (sext_imm),
        .out_wr_reg (out_wr_reg),
        .ctrl       (ctrl),
        .err        (err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(string name, word_t got, word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0d ns: %s got %h expected %h (vector %0d)",
                     $time, name, got, want, vectors);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0d ns: %s got %0d expected %0d (vector %0d)",
                     $time, name, got, want, vectors);
        end
    endtask

    task automatic check_flag(string name, logic got, logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0d ns: %s got %b expected %b (vector %0d)",
                     $time, name, got, want, vectors);
        end
    endtask

    function automatic void name_field(string field);
        $display("    ctrl.%s differs", field);
    endfunction

    task automatic check_ctrl(decode_ctrl_t got, decode_ctrl_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0d ns: ctrl got %h expected %h (vector %0d)",
                     $time, got, want, vectors);
            if (got.br_cnd_sel !== want.br_cnd_sel) name_field("br_cnd_sel");
            if (got.set_sel !== want.set_sel) name_field("set_sel");
            if (got.wr_en !== want.wr_en) name_field("wr_en");
            if (got.has_rt !== want.has_rt) name_field("has_rt");
            if (got.mem_wr_en !== want.mem_wr_en) name_field("mem_wr_en");
            if (got.mem_en !== want.mem_en) name_field("mem_en");
            if (got.wr_sel !== want.wr_sel) name_field("wr_sel");
            if (got.jmp_reg_instr !== want.jmp_reg_instr) name_field("jmp_reg_instr");
            if (got.jmp_instr !== want.jmp_instr) name_field("jmp_instr");
            if (got.br_instr !== want.br_instr) name_field("br_instr");
            if (got.alu_op !== want.alu_op) name_field("alu_op");
            if (got.alu_inv_a !== want.alu_inv_a) name_field("alu_inv_a");
            if (got.alu_inv_b !== want.alu_inv_b) name_field("alu_inv_b");
            if (got.alu_cin !== want.alu_cin) name_field("alu_cin");
            if (got.alu_sign !== want.alu_sign) name_field("alu_sign");
            if (got.halt !== want.halt) name_field("halt");
        end
    endtask

    task automatic compare_outputs();
        check_word("rd_data_1", rd_data_1, exp_rd_data_1);
        check_word("rd_data_2", rd_data_2, exp_rd_data_2);
        check_word("oprnd_2", oprnd_2, exp_oprnd_2);
        check_word("sext_imm", sext_imm, exp_sext_imm);
        check_reg("out_wr_reg", out_wr_reg, exp_wr_reg);
        check_ctrl(ctrl, exp_ctrl_raw);
        check_flag("err", err, exp_err);
    endtask

    task automatic apply_reset();
        int cycles;
        cycles = 0;
        reset  = 1'b1;
        // Hold for the full count and until both ports read cleared registers.
        while (!aborted && (cycles < RESET_CYCLES || rd_data_1 !== '0 || rd_data_2 !== '0)) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            cycles++;
            if (cycles >= RESET_LIMIT) begin
                $display("Timeout: registers still not cleared after %0d reset cycles", cycles);
                errors++;
                aborted = 1'b1;
            end
        end
        reset = 1'b0;
    endtask

    task automatic run_trace();
        int    fd;
        int    n;
        int    cycles;
        string text;
        cycles = 0;
        fd     = $fopen("bench/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/decode_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !aborted) begin
                n = $fgets(text, fd);
                if (n > 0 && text[0] != "#") begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                instr, rd_reg_1, rd_reg_2, wr_en, wr_reg, wr_data,
                                exp_rd_data_1, exp_rd_data_2, exp_oprnd_2, exp_sext_imm,
                                exp_wr_reg, exp_ctrl_raw, exp_err);
                    if (n == 13) begin
                        vectors++;
                        #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_MARGIN); // Just before the edge.
                        compare_outputs();
                        @(posedge clk);
                        #(DRIVE_DELAY);
                        cycles++;
                        if (cycles > TRACE_LIMIT) begin
                            $display("Timeout: trace ran past %0d cycles", TRACE_LIMIT);
                            errors++;
                            aborted = 1'b1;
                        end
                    end else if (n > 0) begin
                        $display("Trace line after vector %0d has %0d fields, not 13",
                                 vectors, n);
                        errors++;
                        aborted = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (!aborted && vectors < MIN_VECTORS) begin
                $display("Trace file is short: %0d vectors, at least %0d needed",
                         vectors, MIN_VECTORS);
                errors++;
            end
        end
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        vectors  = 0;
        aborted  = 1'b0;
        reset    = 1'b1;
        instr    = {OP_NOP, 11'b0}; // NOP while in reset.
        rd_reg_1 = 3'd0;
        rd_reg_2 = 3'd7;
        wr_en    = 1'b0;
        wr_reg   = 3'd0;
        wr_data  = '0;

        apply_reset();
        if (!aborted) begin
            run_trace();
        end

        $display("Errors: %0d, checks: %0d, vectors: %0d", errors, checks, vectors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/decode_trace.txt
# Inputs: instr rd_reg_1 rd_reg_2 wr_en wr_reg wr_data, all hex.
# Expected: rd_data_1 rd_data_2 oprnd_2 sext_imm out_wr_reg ctrl err.
# Register file: cleared state, one write per register, bypass, idle write port.
0800 0 7 0 0 0000  0000 0000 0000 0000 0 000000 0
0800 1 2 1 1 1111  1111 0000 0000 0000 0 000000 0
0800 1 2 1 2 2222  1111 2222 2222 0000 0 000000 0
0800 0 3 1 3 3333  0000 3333 3333 0000 0 000000 0
0800 4 4 1 4 4444  4444 4444 4444 0000 0 000000 0
0800 3 5 1 5 5555  3333 5555 5555 0000 0 000000 0
0800 6 1 1 6 a6a6  a6a6 1111 1111 0000 0 000000 0
0800 2 7 1 7 f00f  2222 f00f f00f 0000 0 000000 0
0800 0 4 1 0 0a0a  0a0a 4444 4444 0000 0 000000 0
0800 3 5 0 3 dead  3333 5555 5555 0000 0 000000 0
0800 7 6 0 0 0000  f00f a6a6 a6a6 0000 0 000000 0
# Immediate ALU forms.
4176 1 2 0 0 0000  1111 2222 fff6 fff6 3 020082 0
4aa7 1 2 0 0 0000  1111 2222 0007 0007 5 020096 0
50df 1 2 0 0 0000  1111 2222 001f 001f 6 0200c0 0
5c30 1 2 0 0 0000  1111 2222 0010 0010 1 0200e8 0
a143 1 2 0 0 0000  1111 2222 0003 0003 2 020000 0
aae4 1 2 0 0 0000  1111 2222 0004 0004 7 020020 0
b311 1 2 0 0 0000  1111 2222 0011 0011 0 020040 0
bd8f 1 2 0 0 0000  1111 2222 000f 000f 4 020060 0
# Memory, BTR, register ALU and shift forms.
815c 1 2 0 0 0000  1111 2222 fffc fffc 7 01c080 0
8b85 1 2 0 0 0000  1111 2222 0005 0005 3 024880 0
9e30 1 2 0 0 0000  1111 2222 fff0 fff0 6 03c080 0
ca0c 1 2 0 0 0000  1111 2222 2222 000c 3 022800 0
d950 1 2 0 0 0000  1111 2222 2222 fff0 4 030082 0
db95 1 2 0 0 0000  1111 2222 2222 fff5 5 030096 0
d83a 1 2 0 0 0000  1111 2222 2222 fffa 6 0300c0 0
da4b 1 2 0 0 0000  1111 2222 2222 000b 2 0300e8 0
d15d 1 2 0 0 0000  1111 2222 2222 fffd 7 030020 0
d147 1 2 0 0 0000  1111 2222 2222 0007 1 030060 0
# Set compares and branches.
e14c 1 2 0 0 0000  1111 2222 2222 000c 3 03188e 0
e950 1 2 0 0 0000  1111 2222 2222 fff0 4 07188e 0
f154 1 2 0 0 0000  1111 2222 2222 fff4 5 0b188e 0
f958 1 2 0 0 0000  1111 2222 2222 fff8 6 0f1880 0
6280 1 2 0 0 0000  1111 2222 2222 ff80 0 000100 0
6905 1 2 0 0 0000  1111 2222 2222 0005 1 100100 0
73fe 1 2 0 0 0000  1111 2222 2222 fffe 7 200100 0
787f 1 2 0 0 0000  1111 2222 2222 007f 7 300100 0
# Byte loads, jumps, halt and the second NOP.
c581 1 2 0 0 0000  1111 2222 ff81 ff81 5 022000 0
94b3 1 2 0 0 0000  1111 2222 00b3 00b3 4 0230a0 0
2401 1 2 0 0 0000  1111 2222 2222 fc01 0 000200 0
2b04 1 2 0 0 0000  1111 2222 0004 0004 1 000680 0
33ff 1 2 0 0 0000  1111 2222 2222 03ff 7 021200 0
3ef8 1 2 0 0 0000  1111 2222 fff8 fff8 7 021680 0
0000 1 2 0 0 0000  1111 2222 2222 0000 0 000001 0
1804 1 2 0 0 0000  1111 2222 2222 0004 1 000000 0
# Undefined opcode, then a legal one clears err.
17ff 1 2 0 0 0000  1111 2222 2222 ffff 7 000000 1
1000 1 2 0 0 0000  1111 2222 2222 0000 0 000000 1
4176 1 2 0 0 0000  1111 2222 fff6 fff6 3 020082 0
# Bypassed write seen through oprnd_2, then stored.
ca0c 1 2 1 2 7777  1111 7777 7777 000c 3 022800 0
0800 2 0 0 0 0000  7777 0a0a 0a0a 0000 0 000000 0

//--- decode.f
rtl/decode_pkg.sv
rtl/reg_file_bypass.sv
rtl/sign_ext.sv
rtl/control.sv
rtl/decode.sv
bench/decode_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wall
TOP      = decode_tb
FILELIST = decode.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a listed source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
